/* b2m_io_golden.txt */
# Steps: T name | W port data | R port byte (-- skips) | A byte | C ticks (decimal)
# P V/T/M level | Q I/O/P/S value, S = {cs_n,sclk,mosi}; other values hex
T reset_ppa
Q I 0  Q O 1  Q P 000000  Q S 5  R 1F 00
W 08 A5  W 09 3C  W 0A 00  R 08 A5  R 09 3C
W 0B 05  W 0B 0F  W 0B 04  W 0B 9B  Q P A53C80  R 0A 80
T pit_modes
W 03 B4  W 02 23  W 02 01  C 16  R 02 13  R 02 01
W 03 76  W 01 06  W 01 00  C 2  Q O 1  C 1  Q O 0  C 3  Q O 1
T cascade
W 15 FD  Q I 1  A CD  A 04  A 38  Q I 0
W 03 B6  W 03 34  W 00 03  W 00 00  W 02 04  W 02 00
C 8  Q I 0  C 4  Q I 1  R 14 02
T acknowledge
W 14 E0  W 15 EE  Q I 0  P V 1  P T 1  Q I 1  R 14 13
A CD  A E0  A 38  Q I 1  A CD  A F0  A 38  Q I 0  R 14 02
W 15 EF  P V 0  P V 1  Q I 0  R 14 03  R 15 EF
T sd_port
Q S 5  W 1A 01  Q S 1  R 1B --  P M 1  W 1B 80  Q S 1
R 1B --  P M 0  W 1B 00  R 1B --  P M 1  W 1B 80  R 1B --  P M 1  W 1B 80
R 1B --  P M 0  W 1B 00  R 1B --  P M 1  W 1B 80  R 1B --  P M 0  W 1B 00
Q S 0  P M 1  R 1B B5  Q S 2  W 1A 00  Q S 6

/* b2m_io.f */
b2m_io_pkg.sv
b2m_port_decode.sv
b2m_pit.sv
b2m_pic.sv
b2m_ppa.sv
b2m_sd_port.sv
b2m_io.sv
b2m_io_asserts.sv
b2m_io_tb.sv

/* b2m_io_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_io_tb import b2m_io_pkg::*; ();

	logic        clk50mhz;
	logic        reset;
	port_bus_t   bus;
	logic        inta, cnt_ce, vid_irq, tape, sd_miso;
	logic [7:0]  rd_data;
	logic        intr, pit_out1, sd_cs_n, sd_sclk, sd_mosi;
	ppa_ports_t  ppa;

	int              fd, r, n_steps, n_ticks;
	int              limit_cycles = 0;  // Watchdog idle until set
	int              tests, failed, checks, errors, test_errors;
	logic            test_open;
	logic [8*32-1:0] test_name;
	logic [8*128-1:0] skip_line;
	int unsigned     seed, idle;

	b2m_io #(.PIC_VEC_HIGH(8'h38)) b2m_io_inst (
		.clk50mhz(clk50mhz), .reset(reset), .bus_i(bus), .inta_i(inta), .cnt_ce_i(cnt_ce),
		.vid_irq_i(vid_irq), .tape_i(tape), .sd_miso_i(sd_miso), .rd_data_o(rd_data),
		.intr_o(intr), .ppa_o(ppa), .pit_out1_o(pit_out1), .sd_cs_n_o(sd_cs_n),
		.sd_sclk_o(sd_sclk), .sd_mosi_o(sd_mosi)
	);

	initial begin
		clk50mhz = 1'b0;
		forever #10 clk50mhz = ~clk50mhz;  // 50 MHz
	end

	// ----------------------------------------
	// Bus and pin drivers
	// ----------------------------------------
	task automatic bus_write(input logic [4:0] a, input logic [7:0] d);
		@(posedge clk50mhz);
		bus.addr  <= a;
		bus.wdata <= d;
		bus.wr    <= 1'b1;
		@(posedge clk50mhz);  // Edge that samples the strobe
		bus.wr <= 1'b0;
	endtask

	task automatic bus_read(input logic [4:0] a);
		@(posedge clk50mhz);
		bus.addr <= a;
		bus.rd   <= 1'b1;
		@(posedge clk50mhz);
		bus.rd <= 1'b0;
		@(negedge clk50mhz);  // rd_data_o settled
	endtask

	task automatic ack_fetch();
		@(posedge clk50mhz);
		inta <= 1'b1;
		@(posedge clk50mhz);
		inta <= 1'b0;
		@(negedge clk50mhz);
	endtask

	// Three quiet cycles let the channel 0 cascade reach the PIC
	task automatic send_ticks(input int n);
		repeat (n) begin
			@(posedge clk50mhz);
			cnt_ce <= 1'b1;
			@(posedge clk50mhz);
			cnt_ce <= 1'b0;
			repeat (3) @(posedge clk50mhz);
		end
	endtask

	task automatic set_level(input logic [7:0] sel, input logic v);
		@(posedge clk50mhz);
		case (sel)
			"V": vid_irq <= v;
			"T": tape    <= v;
			default: sd_miso <= v;  // M
		endcase
		@(posedge clk50mhz);  // Edge latched by the PIC
	endtask

	// ----------------------------------------
	// Checks and bookkeeping
	// ----------------------------------------
	task automatic compare(input logic [8*8-1:0] what, input logic [23:0] expected,
			input logic [23:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("Mismatch %0s: %0s expected %0h, actual %0h", test_name, what,
				expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_pins(input logic [7:0] sel, input logic [23:0] expected);
		@(negedge clk50mhz);
		case (sel)
			"I": compare("intr_o", expected, {23'd0, intr});
			"O": compare("out1", expected, {23'd0, pit_out1});
			"P": compare("ppa_o", expected, ppa);
			default: compare("sd_pins", expected, {21'd0, sd_cs_n, sd_sclk, sd_mosi});
		endcase
	endtask

	task automatic close_test();
		if (test_open) begin
			tests++;
			if (test_errors == 0) begin
				$display("Test %0s: ok", test_name);
			end else begin
				failed++;
				$display("Test %0s: %0d errors", test_name, test_errors);
			end
		end
	endtask

	// Operands count as steps too, so the limit errs long
	task automatic count_steps();
		logic [8*32-1:0] tok;
		int n;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				r = $fgets(skip_line, fd);
			end else if (tok == "C") begin
				r = $fscanf(fd, "%d", n);
				n_ticks += n;
			end else begin
				n_steps++;
			end
		end
	endtask

	task automatic run_golden();
		logic [8*32-1:0] tok;
		logic [8*4-1:0]  exp_tok;
		logic [7:0]      sel;
		logic [4:0]      a;
		logic [23:0]     val;
		int              n;
		while ($fscanf(fd, "%s", tok) == 1) begin
			case (tok)
				"#": r = $fgets(skip_line, fd);  // Comment line
				"T": begin
					close_test();
					r = $fscanf(fd, "%s", test_name);
					test_errors = 0;
					test_open   = 1'b1;
				end
				"W": begin
					r = $fscanf(fd, "%h %h", a, val);
					bus_write(a, val[7:0]);
				end
				"R": begin
					r = $fscanf(fd, "%h %s", a, exp_tok);
					bus_read(a);
					if (exp_tok != "--") begin  // -- only clocks the port
						r = $sscanf(exp_tok, "%h", val);
						compare("rd_data", val, {16'd0, rd_data});
					end
				end
				"A": begin
					r = $fscanf(fd, "%h", val);
					ack_fetch();
					compare("ack_byte", val, {16'd0, rd_data});
				end
				"C": begin
					r = $fscanf(fd, "%d", n);
					send_ticks(n);
				end
				"P": begin
					r = $fscanf(fd, "%s %h", sel, val);
					set_level(sel, val[0]);
				end
				"Q": begin
					r = $fscanf(fd, "%s %h", sel, val);
					check_pins(sel, val);
				end
				default: begin
					$display("Unknown golden step %0s in test %0s", tok, test_name);
					errors++;
					test_errors++;
				end
			endcase
			if (tok != "#" && tok != "T") begin
				idle = $urandom % 4;
				repeat (idle) @(posedge clk50mhz);  // Random gap between steps
			end
		end
	endtask

	// ----------------------------------------
	// Main flow and watchdog
	// ----------------------------------------
	initial begin
		reset     = 1'b1;
		bus       = '0;
		inta      = 1'b0;
		cnt_ce    = 1'b0;
		vid_irq   = 1'b0;
		tape      = 1'b0;
		sd_miso   = 1'b0;
		test_open = 1'b0;
		seed      = 32'h46d2;
		idle      = $urandom(seed);
		fd = $fopen("b2m_io_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open b2m_io_golden.txt");
			errors = 1;
		end else begin
			count_steps();
			$fclose(fd);
			limit_cycles = 40 * n_steps + 6 * n_ticks + 20;
			fd = $fopen("b2m_io_golden.txt", "r");
			repeat (5) @(posedge clk50mhz);
			reset <= 1'b0;
			run_golden();
			close_test();
			$fclose(fd);
		end
		$display("Tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk50mhz);
		$display("Timeout after %0d cycles, golden steps did not complete", limit_cycles);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* b2m_io_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_io_asserts import b2m_io_pkg::*; (
	input wire       clk50mhz,
	input wire       reset,
	input wire [4:0] we_i,        // PIT, PPA, PIC, SD CS, SD data
	input pic_ack_e  ack_state_i,
	input wire       intr_i,
	input wire       sd_cs_n_i
);

	// ----------------------------------------
	// Decoder
	// ----------------------------------------
	one_write_strobe: assert property (@(posedge clk50mhz) disable iff (reset)
		$onehot0(we_i)) else $error("Two device write strobes in one cycle");

	// ----------------------------------------
	// PIC and SD port
	// ----------------------------------------
	intr_only_idle: assert property (@(posedge clk50mhz) disable iff (reset)
		ack_state_i != ACK_IDLE |-> !intr_i) else $error("intr_o high during acknowledge");

	cs_off_in_reset: assert property (@(posedge clk50mhz)
		reset |-> sd_cs_n_i) else $error("SD chip select active during reset");

endmodule

bind b2m_io b2m_io_asserts asserts_inst (
	.clk50mhz(clk50mhz), .reset(reset),
	.we_i({pit_we, ppa_we, pic_we, sd_cs_we, sd_data_we}),
	.ack_state_i(pic_inst.state),
	.intr_i(intr_o), .sd_cs_n_i(sd_cs_n_o)
);

`default_nettype wire

/* b2m_io.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_io import b2m_io_pkg::*; #(
	parameter logic [7:0] PIC_VEC_HIGH = 8'h00
) (
	input  wire        clk50mhz,
	input  wire        reset,
	input  port_bus_t  bus_i,
	input  wire        inta_i,
	input  wire        cnt_ce_i,
	input  wire        vid_irq_i,
	input  wire        tape_i,
	input  wire        sd_miso_i,
	output logic [7:0] rd_data_o,
	output logic       intr_o,
	output ppa_ports_t ppa_o,
	output logic       pit_out1_o,
	output logic       sd_cs_n_o,
	output logic       sd_sclk_o,
	output logic       sd_mosi_o
);

	logic [7:0] pit_rdata, ppa_rdata, pic_rdata, pic_ack, sd_rdata;
	logic       pit_we, pit_rd, ppa_we, pic_we;
	logic       sd_cs_we, sd_data_we, sd_rd;
	logic [2:0] pit_out;
	logic [7:0] irq;

	// Levels: 0 video, 1 timer 0, 4 tape
	assign irq        = {3'b000, tape_i, 2'b00, pit_out[0], vid_irq_i};
	assign pit_out1_o = pit_out[1];  // Sound channel

	// ----------------------------------------
	// Decoder and devices
	// ----------------------------------------
	b2m_port_decode decode_inst (
		.clk50mhz(clk50mhz), .reset(reset), .bus_i(bus_i), .inta_i(inta_i),
		.pit_rdata_i(pit_rdata), .ppa_rdata_i(ppa_rdata), .pic_rdata_i(pic_rdata),
		.pic_ack_i(pic_ack), .sd_rdata_i(sd_rdata),
		.pit_we_o(pit_we), .pit_rd_o(pit_rd), .ppa_we_o(ppa_we), .pic_we_o(pic_we),
		.sd_cs_we_o(sd_cs_we), .sd_data_we_o(sd_data_we), .sd_rd_o(sd_rd),
		.rd_data_o(rd_data_o)
	);

	b2m_pit pit_inst (
		.clk50mhz(clk50mhz), .reset(reset), .we_i(pit_we), .rd_i(pit_rd),
		.addr_i(bus_i.addr[1:0]), .wdata_i(bus_i.wdata), .cnt_ce_i(cnt_ce_i),
		.rdata_o(pit_rdata), .out_o(pit_out)
	);

	b2m_pic #(.PIC_VEC_HIGH(PIC_VEC_HIGH)) pic_inst (
		.clk50mhz(clk50mhz), .reset(reset), .we_i(pic_we), .addr_i(bus_i.addr[0]),
		.wdata_i(bus_i.wdata), .irq_i(irq), .inta_i(inta_i),
		.rdata_o(pic_rdata), .ack_o(pic_ack), .intr_o(intr_o)
	);

	b2m_ppa ppa_inst (
		.clk50mhz(clk50mhz), .reset(reset), .we_i(ppa_we), .addr_i(bus_i.addr[1:0]),
		.wdata_i(bus_i.wdata), .rdata_o(ppa_rdata), .ports_o(ppa_o)
	);

	b2m_sd_port sd_inst (
		.clk50mhz(clk50mhz), .reset(reset), .cs_we_i(sd_cs_we), .data_we_i(sd_data_we),
		.rd_i(sd_rd), .wdata_i(bus_i.wdata), .miso_i(sd_miso_i), .rdata_o(sd_rdata),
		.cs_n_o(sd_cs_n_o), .sclk_o(sd_sclk_o), .mosi_o(sd_mosi_o)
	);

endmodule

`default_nettype wire

/* b2m_sd_port.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_sd_port (
	input  wire        clk50mhz,
	input  wire        reset,
	input  wire        cs_we_i,
	input  wire        data_we_i,
	input  wire        rd_i,
	input  wire  [7:0] wdata_i,
	input  wire        miso_i,
	output logic [7:0] rdata_o,
	output logic       cs_n_o,
	output logic       sclk_o,
	output logic       mosi_o
);

	logic       cs;
	logic [6:0] shift;  // Older MISO samples

	assign cs_n_o  = ~cs;
	assign rdata_o = {shift, miso_i};  // Live bit last

	always_ff @(posedge clk50mhz or posedge reset) begin
		if (reset) begin
			cs     <= 1'b0;
			sclk_o <= 1'b0;
			mosi_o <= 1'b1;  // Idle high
		end else begin
			if (cs_we_i) cs <= wdata_i[0];
			if (data_we_i) begin
				mosi_o <= wdata_i[7];
				sclk_o <= 1'b0;  // Falling edge
			end
			if (rd_i) sclk_o <= 1'b1;  // Rising edge on read
		end
	end

	// Sample on the data write, only after a high clock phase
	always_ff @(posedge clk50mhz) begin
		if (data_we_i && sclk_o) shift <= {shift[5:0], miso_i};
	end

endmodule

`default_nettype wire

/* b2m_ppa.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_ppa import b2m_io_pkg::*; (
	input  wire        clk50mhz,
	input  wire        reset,
	input  wire        we_i,
	input  wire  [1:0] addr_i,
	input  wire  [7:0] wdata_i,
	output logic [7:0] rdata_o,
	output ppa_ports_t ports_o
);

	ppa_ports_t ports;

	assign ports_o = ports;

	// ----------------------------------------
	// Port registers
	// ----------------------------------------
	always_ff @(posedge clk50mhz or posedge reset) begin
		if (reset) begin
			ports <= '0;
		end else if (we_i) begin
			case (addr_i)
				2'd0: ports.a <= wdata_i;
				2'd1: ports.b <= wdata_i;
				2'd2: ports.c <= wdata_i;
				default: begin
					// Bit set/reset on C, mode words dropped
					if (!wdata_i[7]) ports.c[wdata_i[3:1]] <= wdata_i[0];
				end
			endcase
		end
	end

	// Readback of the output latches
	always_comb begin
		case (addr_i)
			2'd0:    rdata_o = ports.a;
			2'd1:    rdata_o = ports.b;
			2'd2:    rdata_o = ports.c;
			default: rdata_o = 8'h00;  // Control port
		endcase
	end

endmodule

`default_nettype wire

/* b2m_pic.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_pic import b2m_io_pkg::*; #(
	parameter logic [7:0] PIC_VEC_HIGH = 8'h00
) (
	input  wire        clk50mhz,
	input  wire        reset,
	input  wire        we_i,
	input  wire        addr_i,
	input  wire  [7:0] wdata_i,
	input  wire  [7:0] irq_i,
	input  wire        inta_i,
	output logic [7:0] rdata_o,
	output logic [7:0] ack_o,
	output logic       intr_o
);

	logic [7:0] req;      // Latched requests
	logic [7:0] mask;     // 1 = masked
	logic [7:0] irq_q;
	logic [2:0] base;     // Vector low bits 7:5
	logic [2:0] level;    // Level being acknowledged
	logic [2:0] win;
	logic [7:0] pending;
	logic [7:0] clr;
	pic_ack_e   state;

	assign pending = req & ~mask;
	assign intr_o  = state == ACK_IDLE && |pending;
	assign rdata_o = addr_i ? mask : req;

	// Fixed priority, level 0 highest
	always_comb begin
		win = 3'd0;
		for (int i = 7; i >= 0; i--) begin
			if (pending[i]) win = 3'(i);
		end
	end

	// First acknowledge byte retires the winner
	assign clr = (inta_i && intr_o) ? (8'h01 << win) : 8'h00;

	always_ff @(posedge clk50mhz or posedge reset) begin
		if (reset) begin
			req   <= 8'h00;
			mask  <= 8'hFF;  // All masked
			irq_q <= 8'h00;
			base  <= 3'd0;
			level <= 3'd0;
			state <= ACK_IDLE;
		end else begin
			irq_q <= irq_i;
			req   <= (req & ~clr) | (irq_i & ~irq_q);  // Rising edges only
			if (we_i) begin
				if (addr_i) mask <= wdata_i;
				else        base <= wdata_i[7:5];
			end
			if (inta_i) begin
				case (state)
					ACK_IDLE: begin
						level <= win;
						state <= ACK_LOW;
					end
					ACK_LOW:  state <= ACK_HIGH;
					default:  state <= ACK_IDLE;
				endcase
			end
		end
	end

	// Byte for the current fetch
	always_comb begin
		case (state)
			ACK_IDLE: ack_o = CALL_OPCODE;
			ACK_LOW:  ack_o = {base, level, 2'b00};  // Base + 4 * level
			default:  ack_o = PIC_VEC_HIGH;
		endcase
	end

endmodule

`default_nettype wire

/* b2m_pit.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_pit import b2m_io_pkg::*; (
	input  wire        clk50mhz,
	input  wire        reset,
	input  wire        we_i,
	input  wire        rd_i,
	input  wire  [1:0] addr_i,
	input  wire  [7:0] wdata_i,
	input  wire        cnt_ce_i,
	output logic [7:0] rdata_o,
	output logic [2:0] out_o
);

	logic [15:0] count [3];
	logic [15:0] reload [3];
	pit_mode_e   mode [3];
	logic [2:0]  wr_msb;   // Next data write is MSB
	logic [2:0]  rd_msb;   // Next read is MSB
	logic [2:0]  armed;    // Count loaded
	logic [2:0]  out;
	logic [2:0]  tick;
	logic        out2_q;   // For the channel 0 clock edge
	logic        ctl_we;
	pit_mode_e   ctl_mode;

	assign ctl_we   = we_i && addr_i == 2'd3;
	assign ctl_mode = wdata_i[1] ? PIT_SQUARE : PIT_RATE;  // Modes 2/3 only, 6/7 alias
	assign tick     = {cnt_ce_i, cnt_ce_i, out[2] & ~out2_q};
	assign out_o    = out;

	always_ff @(posedge clk50mhz or posedge reset) begin
		if (reset) begin
			out2_q <= 1'b1;
			wr_msb <= 3'b000;
			rd_msb <= 3'b000;
			armed  <= 3'b000;
			out    <= 3'b111;
			for (int i = 0; i < 3; i++) begin
				count[i]  <= 16'h0000;
				reload[i] <= 16'h0000;
				mode[i]   <= PIT_RATE;
			end
		end else begin
			out2_q <= out[2];
			for (int i = 0; i < 3; i++) begin
				if (ctl_we && wdata_i[7:6] == 2'(i)) begin
					// Control word stops the channel
					mode[i]   <= ctl_mode;
					wr_msb[i] <= 1'b0;
					rd_msb[i] <= 1'b0;
					armed[i]  <= 1'b0;
					out[i]    <= 1'b1;
				end else if (we_i && addr_i == 2'(i)) begin
					if (!wr_msb[i]) begin
						reload[i][7:0] <= wdata_i;  // LSB
						wr_msb[i]      <= 1'b1;
					end else begin
						reload[i][15:8] <= wdata_i;
						wr_msb[i]       <= 1'b0;
						armed[i]        <= 1'b1;
						// Square wave counts even values only
						if (mode[i] == PIT_SQUARE) count[i] <= {wdata_i, reload[i][7:1], 1'b0};
						else                       count[i] <= {wdata_i, reload[i][7:0]};
					end
				end else if (tick[i] && armed[i]) begin
					if (mode[i] == PIT_SQUARE) begin
						if (count[i] == 16'd2) begin
							count[i] <= {reload[i][15:1], 1'b0};
							out[i]   <= ~out[i];  // Half period done
						end else begin
							count[i] <= count[i] - 16'd2;
						end
					end else if (count[i] == 16'd1) begin
						count[i] <= reload[i];
						out[i]   <= 1'b1;  // End of low pulse
					end else begin
						count[i] <= count[i] - 16'd1;
						if (count[i] == 16'd2) out[i] <= 1'b0;  // Low while count is 1
					end
				end
				if (rd_i && addr_i == 2'(i)) rd_msb[i] <= ~rd_msb[i];
			end
		end
	end

	// Live count, byte by pointer
	always_comb begin
		rdata_o = 8'h00;
		if (addr_i != 2'd3) rdata_o = rd_msb[addr_i] ? count[addr_i][15:8] : count[addr_i][7:0];
	end

endmodule

`default_nettype wire

/* b2m_port_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module b2m_port_decode import b2m_io_pkg::*; (
	input  wire        clk50mhz,
	input  wire        reset,
	input  port_bus_t  bus_i,
	input  wire        inta_i,
	input  wire  [7:0] pit_rdata_i,
	input  wire  [7:0] ppa_rdata_i,
	input  wire  [7:0] pic_rdata_i,
	input  wire  [7:0] pic_ack_i,
	input  wire  [7:0] sd_rdata_i,
	output logic       pit_we_o,
	output logic       pit_rd_o,
	output logic       ppa_we_o,
	output logic       pic_we_o,
	output logic       sd_cs_we_o,
	output logic       sd_data_we_o,
	output logic       sd_rd_o,
	output logic [7:0] rd_data_o
);

	io_dev_e dev;

	// Address match, block sizes 4, 4, 2, 1, 1
	always_comb begin
		if (bus_i.addr[4:2] == PIT_BASE[4:2])      dev = DEV_PIT;
		else if (bus_i.addr[4:2] == PPA_BASE[4:2]) dev = DEV_PPA;
		else if (bus_i.addr[4:1] == PIC_BASE[4:1]) dev = DEV_PIC;
		else if (bus_i.addr == SD_CS_PORT)         dev = DEV_SD_CS;
		else if (bus_i.addr == SD_DATA_PORT)       dev = DEV_SD_DATA;
		else                                       dev = DEV_NONE;
	end

	// Strobes gated by the match
	assign pit_we_o     = bus_i.wr && dev == DEV_PIT;
	assign ppa_we_o     = bus_i.wr && dev == DEV_PPA;
	assign pic_we_o     = bus_i.wr && dev == DEV_PIC;
	assign sd_cs_we_o   = bus_i.wr && dev == DEV_SD_CS;
	assign sd_data_we_o = bus_i.wr && dev == DEV_SD_DATA;
	assign pit_rd_o     = bus_i.rd && dev == DEV_PIT;   // Steps the PIT byte pointer
	assign sd_rd_o      = bus_i.rd && dev == DEV_SD_DATA; // Raises SD clock

	// Registered read byte, held between strobes
	always_ff @(posedge clk50mhz or posedge reset) begin
		if (reset) begin
			rd_data_o <= 8'h00;
		end else if (inta_i) begin
			rd_data_o <= pic_ack_i;  // Acknowledge byte wins
		end else if (bus_i.rd) begin
			case (dev)
				DEV_PIT:     rd_data_o <= pit_rdata_i;
				DEV_PPA:     rd_data_o <= ppa_rdata_i;
				DEV_PIC:     rd_data_o <= pic_rdata_i;
				DEV_SD_DATA: rd_data_o <= sd_rdata_i;
				default:     rd_data_o <= 8'h00;  // CS port and holes
			endcase
		end
	end

endmodule

`default_nettype wire

/* b2m_io_pkg.sv */
`default_nettype none

package b2m_io_pkg;

	// ----------------------------------------
	// CPU port bus
	// ----------------------------------------
	typedef struct packed {
		logic [4:0] addr;   // Port number, A4..A0
		logic [7:0] wdata;  // Write byte
		logic       wr;     // One-cycle write strobe
		logic       rd;     // One-cycle read strobe
	} port_bus_t;

	// Device selected by the port map
	typedef enum logic [2:0] {
		DEV_NONE    = 3'd0,
		DEV_PIT     = 3'd1,
		DEV_PPA     = 3'd2,
		DEV_PIC     = 3'd3,
		DEV_SD_CS   = 3'd4,
		DEV_SD_DATA = 3'd5
	} io_dev_e;

	// Timer modes, numbered as in the control word
	typedef enum logic [2:0] {
		PIT_RATE   = 3'd2,  // Rate generator
		PIT_SQUARE = 3'd3   // Square wave
	} pit_mode_e;

	// Three-byte acknowledge sequence
	typedef enum logic [1:0] {
		ACK_IDLE = 2'd0,
		ACK_LOW  = 2'd1,  // Next byte is vector low
		ACK_HIGH = 2'd2   // Next byte is vector high
	} pic_ack_e;

	// Parallel port outputs
	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;  // C[2:0] is the memory map
	} ppa_ports_t;

	// ----------------------------------------
	// Port map
	// ----------------------------------------
	localparam logic [4:0] PIT_BASE     = 5'd0;   // 000xx
	localparam logic [4:0] PPA_BASE     = 5'd8;   // 010xx
	localparam logic [4:0] PIC_BASE     = 5'd20;  // 1010x
	localparam logic [4:0] SD_CS_PORT   = 5'd26;  // 11010
	localparam logic [4:0] SD_DATA_PORT = 5'd27;  // 11011

	localparam logic [7:0] CALL_OPCODE = 8'hCD;  // 8080 CALL

endpackage

`default_nettype wire
